//--- Makefile
TOP := cart_loader_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f cart_loader_top.f -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

lint:
	verilator --lint-only -Wall --timing --top-module cart_loader_top -f cart_loader_top.f

clean:
	rm -rf obj_dir

//--- cart_loader_top.f
common/cart_pkg.sv
loader/rom_writer.sv
loader/cart_info.sv
verilog/cheat_assembler.sv
verilog/rom_store.sv
verilog/cart_loader_top.sv
verif/cart_loader_props.sv
verif/cart_loader_checker.sv
verif/cart_loader_tb.sv

//--- common/cart_pkg.sv
// Shared types, download indices and cartridge constants for the loader; used by scoped names
package cart_pkg;

	// ========================================================================
	// Data and address types
	// ========================================================================

	typedef logic [7:0]  byte_t;     // Download and ROM data byte
	typedef logic [24:0] dl_addr_t;  // Host port byte address
	typedef logic [7:0]  dl_index_t; // Selects what is being loaded
	typedef logic [15:0] rom_addr_t; // 64 KB ROM store
	typedef logic [31:0] word32_t;   // One cheat record field

	// ========================================================================
	// Download indices
	// ========================================================================

	localparam dl_index_t IDX_SMS   = 8'd1;
	localparam dl_index_t IDX_GG    = 8'd2;   // Handheld cartridge
	localparam dl_index_t IDX_CHEAT = 8'd255; // Cheat codes, never a cartridge

	// Cartridge ID for the video chip quirk
	// Four bytes at the base, first byte most significant
	localparam word32_t  QUIRK_ID      = 32'h1370_014F;
	localparam dl_addr_t ID_BASE_ADDR  = 25'h000_7FFC;
	localparam dl_addr_t ID_CHECK_ADDR = 25'h000_8000; // Write here triggers compare

	// ========================================================================
	// Cheat record layout
	// ========================================================================

	// Flags, address, compare, replace in offset order
	localparam int CHEAT_BYTES = 16;
	localparam int FIELD_BYTES = 4;
	localparam int CHEAT_OFS_W = $clog2(CHEAT_BYTES);
	localparam int FIELD_SEL_W = $clog2(FIELD_BYTES);

endpackage

//--- loader/cart_info.sv
`timescale 1ns/1ps
// Cartridge information tracker, builds the address mask, handheld flag and VDP quirk flag
module cart_info #(
	parameter int ROM_AW = 16
) (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                dl_active,
	input  cart_pkg::dl_index_t dl_index,
	input  cart_pkg::dl_addr_t  dl_addr,
	input  cart_pkg::byte_t     dl_data,
	input  logic                dl_wr,
	output logic [ROM_AW-1:0]   cart_mask,
	output logic                is_gg,
	output logic                vdp_quirk
);

	logic              cart_dl;
	logic              old_dl;
	logic              dl_start;
	logic              cart_wr;
	logic              id_byte;  // Write falls in the ID window
	logic [1:0]        id_sel;
	cart_pkg::word32_t cart_id;

	assign cart_dl  = dl_active & (dl_index != cart_pkg::IDX_CHEAT);
	assign dl_start = cart_dl & ~old_dl;
	assign cart_wr  = dl_wr & cart_dl;

	// ID window is four aligned bytes
	assign id_byte = (dl_addr[24:2] == cart_pkg::ID_BASE_ADDR[24:2]);
	assign id_sel  = dl_addr[1:0];

	// ========================================================================
	// Mask and handheld flag
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_dl    <= 1'b0;
			cart_mask <= '0;
			is_gg     <= 1'b0;
		end else begin
			old_dl <= cart_dl;
			if (cart_wr) begin
				// Address zero begins a fresh image
				if (dl_addr == '0) begin
					cart_mask <= '0;
				end else begin
					cart_mask <= cart_mask | dl_addr[ROM_AW-1:0];
				end
				is_gg <= (dl_index == cart_pkg::IDX_GG);
			end
		end
	end

	// ID bytes, first one lands in the top byte
	always_ff @(posedge clk_sys) begin
		if (cart_wr && id_byte) begin
			cart_id[8*(3-id_sel) +: 8] <= dl_data;
		end
	end

	// Quirk flag, cleared per cartridge and set only on a matching ID
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			vdp_quirk <= 1'b0;
		end else begin
			if (dl_start) begin
				vdp_quirk <= 1'b0;
			end
			if (cart_wr && (dl_addr == cart_pkg::ID_CHECK_ADDR) &&
				(cart_id == cart_pkg::QUIRK_ID)) begin
				vdp_quirk <= 1'b1;
			end
		end
	end

endmodule

//--- loader/rom_writer.sv
`timescale 1ns/1ps
// Cartridge byte writer, turns host download strobes into toggle requests to the ROM store
module rom_writer #(
	parameter int ROM_AW = 16
) (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                dl_active,
	input  cart_pkg::dl_index_t dl_index,
	input  cart_pkg::byte_t     dl_data,
	input  logic                dl_wr,
	output logic                dl_wait,
	output logic                wr_req,
	output logic [ROM_AW-1:0]   wr_addr,
	output cart_pkg::byte_t     wr_data,
	input  logic                wr_ack
);

	logic cart_dl;   // Cartridge download in progress
	logic old_dl;
	logic dl_start;
	logic wr_accept;
	logic wr_done;

	// Anything but the cheat index loads a cartridge
	assign cart_dl   = dl_active & (dl_index != cart_pkg::IDX_CHEAT);
	assign dl_start  = cart_dl & ~old_dl;
	assign wr_accept = dl_wr & cart_dl;

	// Store has caught up once the ack matches the request
	assign wr_done = dl_wait & (wr_req == wr_ack);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_dl <= 1'b0;
		end else begin
			old_dl <= cart_dl;
		end
	end

	// ========================================================================
	// Request toggle, wait flag and address counter
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_wait <= 1'b0;
			wr_req  <= 1'b0;
			wr_addr <= '0;
		end else begin
			if (wr_accept) begin
				dl_wait <= 1'b1;    // Hold host off until ack
				wr_req  <= ~wr_req; // One flip per byte
			end else if (wr_done) begin
				dl_wait <= 1'b0;
				wr_addr <= wr_addr + 1'b1;
			end

			// New cartridge starts at address zero
			if (dl_start) begin
				wr_addr <= '0;
			end
		end
	end

	// Data byte held stable for the whole handshake
	always_ff @(posedge clk_sys) begin
		if (wr_accept) begin
			wr_data <= dl_data;
		end
	end

endmodule

//--- verif/cart_loader_checker.sv
`timescale 1ns/1ps
// Scoreboard in the loader testbench that models image, mask, ID, cheat fields and wait timing
module cart_loader_checker #(
	parameter int WR_LATENCY = 3
) (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                dl_active,
	input  cart_pkg::dl_index_t dl_index,
	input  cart_pkg::dl_addr_t  dl_addr,
	input  cart_pkg::byte_t     dl_data,
	input  logic                dl_wr,
	input  logic                dl_wait,
	input  cart_pkg::rom_addr_t rd_addr,
	input  cart_pkg::byte_t     rd_data,
	input  cart_pkg::rom_addr_t cart_mask,
	input  logic                is_gg,
	input  logic                vdp_quirk,
	input  logic                code_valid,
	input  cart_pkg::word32_t   code_flags,
	input  cart_pkg::word32_t   code_addr,
	input  cart_pkg::word32_t   code_compare,
	input  cart_pkg::word32_t   code_replace,
	input  logic                tests_done,
	output int                  error_count,
	output logic                checks_done
);

	localparam int MEM_SIZE = 2 ** $bits(cart_pkg::rom_addr_t);

	cart_pkg::byte_t     model_mem [MEM_SIZE];
	bit                  known [MEM_SIZE];   // Location written at least once
	cart_pkg::rom_addr_t model_mask;
	logic                model_gg;
	logic                model_quirk;
	cart_pkg::word32_t   model_id;
	cart_pkg::word32_t   model_fields [4];   // Flags, address, compare, replace
	cart_pkg::word32_t   exp_fields [4];
	logic                exp_valid;
	int                  wr_times [$];       // Edge at which each byte was taken
	int                  cyc = 0;
	int                  errors = 0;
	int                  checks = 0;
	int                  rd_checks = 0;
	int                  writes_seen = 0;
	int                  accepts_seen = 0;
	int                  records_made = 0;
	int                  records_seen = 0;
	int                  ofs;
	logic                done = 1'b0;
	logic                rst_seen = 1'b0;
	logic                prev_active;
	logic                prev_cart;
	logic                prev_wait;
	logic                rd_armed;
	cart_pkg::rom_addr_t rd_prev;
	logic                cart_wr;
	logic                cheat_wr;

	assign error_count = errors;
	assign checks_done = done;
	assign cart_wr  = dl_active && dl_wr && (dl_index != cart_pkg::IDX_CHEAT);
	assign cheat_wr = dl_active && dl_wr && (dl_index == cart_pkg::IDX_CHEAT);

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("ERROR: %s", what);
	endtask

	always @(posedge clk_sys) begin
		cyc      <= cyc + 1;
		rst_seen <= RESET;
	end

	// ========================================================================
	// Sampling on the falling edge
	// ========================================================================

	always @(negedge clk_sys) begin
		if (RESET) begin
			if (rst_seen) begin
				compare_value("reset_dl_wait", 0, dl_wait);
				compare_value("reset_code_valid", 0, code_valid);
				compare_value("reset_is_gg", 0, is_gg);
				compare_value("reset_vdp_quirk", 0, vdp_quirk);
				compare_value("reset_cart_mask", 0, cart_mask);
			end
			prev_active = 1'b0;
			prev_cart   = 1'b0;
			prev_wait   = 1'b0;
			rd_armed    = 1'b0;
			exp_valid   = 1'b0;
			model_mask  = '0;
			model_gg    = 1'b0;
			model_quirk = 1'b0;
			wr_times.delete();
		end else begin
			// Read issued last cycle while idle
			if (rd_armed && known[rd_prev]) begin
				compare_value("rom_readback", model_mem[rd_prev], rd_data);
				rd_checks++;
			end
			rd_armed = !dl_active;
			rd_prev  = rd_addr & model_mask;

			if (exp_valid) begin
				compare_value("cheat_valid", 1, code_valid);
				compare_value("cheat_flags", exp_fields[0], code_flags);
				compare_value("cheat_addr", exp_fields[1], code_addr);
				compare_value("cheat_compare", exp_fields[2], code_compare);
				compare_value("cheat_replace", exp_fields[3], code_replace);
				if (code_valid) begin
					records_seen++;
				end
			end else if (code_valid) begin
				report_problem("code_valid pulsed without a complete cheat record");
			end
			exp_valid = 1'b0;

			// Each release of dl_wait closes the oldest write
			if (prev_wait && !dl_wait) begin
				if (wr_times.size() == 0) begin
					report_problem("dl_wait fell with no cartridge byte pending");
				end else begin
					compare_value("wait_latency", WR_LATENCY + 2, cyc - wr_times.pop_front());
					accepts_seen++;
				end
			end
			if (dl_wait && dl_active && dl_index == cart_pkg::IDX_CHEAT) begin
				report_problem("dl_wait went high during a cheat download");
			end
			prev_wait = dl_wait;

			if (prev_active && !dl_active && prev_cart) begin
				compare_value("cart_mask", model_mask, cart_mask);
				compare_value("is_gg", model_gg, is_gg);
				compare_value("vdp_quirk", model_quirk, vdp_quirk);
			end
			if (dl_active && !prev_active && dl_index != cart_pkg::IDX_CHEAT) begin
				model_quirk = 1'b0;  // New cartridge
			end
			prev_active = dl_active;
			prev_cart   = (dl_index != cart_pkg::IDX_CHEAT);

			if (cart_wr) begin
				model_mem[cart_pkg::rom_addr_t'(dl_addr)] = dl_data;
				known[cart_pkg::rom_addr_t'(dl_addr)]     = 1'b1;
				if (dl_addr == '0) begin
					model_mask = '0;
				end
				model_mask = model_mask | cart_pkg::rom_addr_t'(dl_addr);
				model_gg   = (dl_index == cart_pkg::IDX_GG);
				if (dl_addr >= cart_pkg::ID_BASE_ADDR &&
					dl_addr < cart_pkg::ID_BASE_ADDR + 4) begin
					model_id = {model_id[23:0], dl_data};  // First byte ends up on top
				end
				if (dl_addr == cart_pkg::ID_CHECK_ADDR && model_id == cart_pkg::QUIRK_ID) begin
					model_quirk = 1'b1;
				end
				wr_times.push_back(cyc + 1);
				writes_seen++;
			end

			if (cheat_wr) begin
				ofs = int'(dl_addr % cart_pkg::CHEAT_BYTES);
				model_fields[ofs / 4][8 * (ofs % 4) +: 8] = dl_data;
				if (ofs == cart_pkg::CHEAT_BYTES - 1) begin
					exp_fields = model_fields;
					exp_valid  = 1'b1;
					records_made++;
				end
			end

			if (tests_done && !done) begin
				if (wr_times.size() != 0) begin
					report_problem("cartridge bytes were never released by dl_wait");
				end
				compare_value("bytes_accepted", writes_seen, accepts_seen);
				compare_value("cheat_records", records_made, records_seen);
				if (rd_checks == 0) begin
					report_problem("no ROM readback was compared");
				end
				$display("Closing: %0d checks, %0d errors", checks, errors);
				done = 1'b1;
			end
		end
	end

endmodule

//--- verif/cart_loader_props.sv
`timescale 1ns/1ps
// Download port protocol assertions, attached to the loader top level by the bind below
module cart_loader_props (
	input logic                clk_sys,
	input logic                RESET,
	input logic                dl_active,
	input cart_pkg::dl_index_t dl_index,
	input logic                dl_wr,
	input logic                dl_wait,
	input logic                code_valid
);

	logic cart_wr;
	logic cheat_wr;

	assign cart_wr  = dl_active & dl_wr & (dl_index != cart_pkg::IDX_CHEAT);
	assign cheat_wr = dl_active & dl_wr & (dl_index == cart_pkg::IDX_CHEAT);

	// Host holds off while the store is busy
	no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (RESET) dl_wr |-> !dl_wait)
		else $error("dl_wr issued while dl_wait was high");

	wait_after_cart: assert property (@(posedge clk_sys) disable iff (RESET) cart_wr |=> dl_wait)
		else $error("dl_wait did not rise after a cartridge write");

	cheat_no_wait: assert property (@(posedge clk_sys) disable iff (RESET) cheat_wr |=> !dl_wait)
		else $error("dl_wait rose after a cheat write");

	valid_one_cycle: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid lasted more than one cycle");

endmodule

bind cart_loader_top cart_loader_props u_cart_loader_props (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.dl_active  (dl_active),
	.dl_index   (dl_index),
	.dl_wr      (dl_wr),
	.dl_wait    (dl_wait),
	.code_valid (code_valid)
);

//--- verif/cart_loader_tb.sv
`timescale 1ns/1ps
// Testbench top that runs seeded random downloads, reads and cheat records through the loader
module cart_loader_tb;

	localparam int WR_LATENCY = 3;
	localparam int SEED       = 25292;
	localparam int NUM_READS  = 64;
	localparam int NUM_CHEATS = 8;
	localparam int QUIRK_LEN  = 'h8001;  // Reaches the ID check address

	logic                clk_sys;
	logic                RESET;
	logic                dl_active;
	cart_pkg::dl_index_t dl_index;
	cart_pkg::dl_addr_t  dl_addr;
	cart_pkg::byte_t     dl_data;
	logic                dl_wr;
	logic                dl_wait;
	cart_pkg::rom_addr_t rd_addr;
	cart_pkg::byte_t     rd_data;
	cart_pkg::rom_addr_t cart_mask;
	logic                is_gg;
	logic                vdp_quirk;
	logic                code_valid;
	cart_pkg::word32_t   code_flags;
	cart_pkg::word32_t   code_addr;
	cart_pkg::word32_t   code_compare;
	cart_pkg::word32_t   code_replace;
	logic                tests_done;
	logic                checks_done;
	int                  error_count;
	int                  len_a;
	int                  len_b;
	int                  limit_cycles = 0;
	cart_pkg::word32_t   other_id;

	cart_loader_top #(
		.WR_LATENCY(WR_LATENCY)
	) u_cart_loader_top (
		.clk_sys(clk_sys), .RESET(RESET), .dl_active(dl_active), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data), .dl_wr(dl_wr), .dl_wait(dl_wait),
		.rd_addr(rd_addr), .rd_data(rd_data), .cart_mask(cart_mask), .is_gg(is_gg),
		.vdp_quirk(vdp_quirk), .code_valid(code_valid), .code_flags(code_flags),
		.code_addr(code_addr), .code_compare(code_compare), .code_replace(code_replace)
	);

	cart_loader_checker #(
		.WR_LATENCY(WR_LATENCY)
	) u_checker (
		.clk_sys(clk_sys), .RESET(RESET), .dl_active(dl_active), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data), .dl_wr(dl_wr), .dl_wait(dl_wait),
		.rd_addr(rd_addr), .rd_data(rd_data), .cart_mask(cart_mask), .is_gg(is_gg),
		.vdp_quirk(vdp_quirk), .code_valid(code_valid), .code_flags(code_flags),
		.code_addr(code_addr), .code_compare(code_compare), .code_replace(code_replace),
		.tests_done(tests_done), .error_count(error_count), .checks_done(checks_done)
	);

	// 40 ns clock
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Watchdog armed once the download lengths are known
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_sys);
		$display("Timeout after %0d cycles, the DUT stopped responding", limit_cycles);
		$display("TB FAILED");
		$finish;
	end

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#2;
	endtask

	// One host strobe once the port is free
	task automatic send_byte(input cart_pkg::dl_addr_t addr, input cart_pkg::byte_t data);
		while (dl_wait) begin
			idle_cycles(1);
		end
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		idle_cycles(1);
		dl_wr = 1'b0;
	endtask

	task automatic finish_download;
		while (dl_wait) begin
			idle_cycles(1);
		end
		dl_active = 1'b0;
		idle_cycles(3);
	endtask

	// Random image with an optional cartridge ID in the ID window
	task automatic load_cartridge(input cart_pkg::dl_index_t idx, input int len,
		input cart_pkg::word32_t id, input bit with_id);
		int k;
		cart_pkg::byte_t b;
		dl_index  = idx;
		dl_active = 1'b1;
		idle_cycles(1);
		for (int i = 0; i < len; i++) begin
			b = cart_pkg::byte_t'($urandom);
			k = i - int'(cart_pkg::ID_BASE_ADDR);
			if (with_id && k >= 0 && k < 4) begin
				b = cart_pkg::byte_t'(id >> (8 * (3 - k)));  // First byte on top
			end
			send_byte(cart_pkg::dl_addr_t'(i), b);
		end
		finish_download();
	endtask

	task automatic load_cheats(input int count);
		dl_index  = cart_pkg::IDX_CHEAT;
		dl_active = 1'b1;
		idle_cycles(1);
		for (int i = 0; i < count * cart_pkg::CHEAT_BYTES; i++) begin
			send_byte(cart_pkg::dl_addr_t'(i), cart_pkg::byte_t'($urandom));
		end
		finish_download();
	endtask

	// Half the reads land inside the image and half anywhere so they wrap
	task automatic random_reads(input int n, input int span);
		for (int i = 0; i < n; i++) begin
			if (i % 2 == 0) begin
				rd_addr = cart_pkg::rom_addr_t'($urandom % span);
			end else begin
				rd_addr = cart_pkg::rom_addr_t'($urandom);
			end
			idle_cycles(1);
		end
		idle_cycles(2);
	endtask

	initial begin
		void'($urandom(SEED));
		RESET      = 1'b1;
		dl_active  = 1'b0;
		dl_index   = cart_pkg::IDX_SMS;
		dl_addr    = '0;
		dl_data    = '0;
		dl_wr      = 1'b0;
		rd_addr    = '0;
		tests_done = 1'b0;

		len_a = 256 << ($urandom % 5);
		len_b = len_a >> (1 + $urandom % 2);  // Shorter image for the mask test
		limit_cycles = (len_a + len_b + 2 * QUIRK_LEN + NUM_CHEATS * cart_pkg::CHEAT_BYTES)
			* (WR_LATENCY + 6) + 2000;

		repeat (10) @(posedge clk_sys);
		#2;
		RESET = 1'b0;
		idle_cycles(4);

		// Readback and then a shorter handheld image
		load_cartridge(cart_pkg::IDX_SMS, len_a, '0, 1'b0);
		random_reads(NUM_READS, len_a);
		load_cartridge(cart_pkg::IDX_GG, len_b, '0, 1'b0);
		random_reads(NUM_READS, len_b);

		// Quirk ID first and then any other ID
		load_cartridge(cart_pkg::IDX_SMS, QUIRK_LEN, cart_pkg::QUIRK_ID, 1'b1);
		do begin
			other_id = $urandom;
		end while (other_id == cart_pkg::QUIRK_ID);
		load_cartridge(cart_pkg::IDX_SMS, QUIRK_LEN, other_id, 1'b1);
		random_reads(NUM_READS, QUIRK_LEN);

		load_cheats(NUM_CHEATS);

		tests_done = 1'b1;
		wait (checks_done);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/cart_loader_top.sv
`timescale 1ns/1ps
// Cartridge loading path top level, connects the download port to the ROM store and trackers
module cart_loader_top #(
	parameter int WR_LATENCY = 3
) (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                dl_active,
	input  cart_pkg::dl_index_t dl_index,
	input  cart_pkg::dl_addr_t  dl_addr,
	input  cart_pkg::byte_t     dl_data,
	input  logic                dl_wr,
	output logic                dl_wait,
	input  cart_pkg::rom_addr_t rd_addr,
	output cart_pkg::byte_t     rd_data,
	output cart_pkg::rom_addr_t cart_mask,
	output logic                is_gg,
	output logic                vdp_quirk,
	output logic                code_valid,
	output cart_pkg::word32_t   code_flags,
	output cart_pkg::word32_t   code_addr,
	output cart_pkg::word32_t   code_compare,
	output cart_pkg::word32_t   code_replace
);

	localparam int ROM_AW = $bits(cart_pkg::rom_addr_t);

	// ROM write handshake
	logic                wr_req;
	logic                wr_ack;
	cart_pkg::rom_addr_t wr_addr;
	cart_pkg::byte_t     wr_data;

	rom_writer #(
		.ROM_AW(ROM_AW)
	) u_rom_writer (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_data   (dl_data),
		.dl_wr     (dl_wr),
		.dl_wait   (dl_wait),
		.wr_req    (wr_req),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_ack    (wr_ack)
	);

	cart_info #(
		.ROM_AW(ROM_AW)
	) u_cart_info (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_wr     (dl_wr),
		.cart_mask (cart_mask),
		.is_gg     (is_gg),
		.vdp_quirk (vdp_quirk)
	);

	cheat_assembler u_cheat_assembler (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.dl_wr        (dl_wr),
		.code_flags   (code_flags),
		.code_addr    (code_addr),
		.code_compare (code_compare),
		.code_replace (code_replace),
		.code_valid   (code_valid)
	);

	rom_store #(
		.ROM_AW     (ROM_AW),
		.WR_LATENCY (WR_LATENCY)
	) u_rom_store (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.wr_req    (wr_req),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_ack    (wr_ack),
		.rd_addr   (rd_addr),
		.cart_mask (cart_mask),
		.rd_data   (rd_data)
	);

endmodule

//--- verilog/cheat_assembler.sv
`timescale 1ns/1ps
// Cheat code collector, gathers 16 download bytes into one record and strobes it out
module cheat_assembler (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                dl_active,
	input  cart_pkg::dl_index_t dl_index,
	input  cart_pkg::dl_addr_t  dl_addr,
	input  cart_pkg::byte_t     dl_data,
	input  logic                dl_wr,
	output cart_pkg::word32_t   code_flags,
	output cart_pkg::word32_t   code_addr,
	output cart_pkg::word32_t   code_compare,
	output cart_pkg::word32_t   code_replace,
	output logic                code_valid
);

	localparam int OFS_W = cart_pkg::CHEAT_OFS_W;
	localparam int SEL_W = cart_pkg::FIELD_SEL_W;

	logic                         code_wr;
	logic [OFS_W-1:0]             ofs;       // Byte offset in the record
	logic [OFS_W-SEL_W-1:0]       field;
	logic [SEL_W-1:0]             byte_sel;  // Lower offset is lower byte

	assign code_wr  = dl_active & dl_wr & (dl_index == cart_pkg::IDX_CHEAT);
	assign ofs      = dl_addr[OFS_W-1:0];
	assign field    = ofs[OFS_W-1:SEL_W];
	assign byte_sel = ofs[SEL_W-1:0];

	// ========================================================================
	// Field registers
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (field)
				2'd0:    code_flags[8*byte_sel +: 8]   <= dl_data;
				2'd1:    code_addr[8*byte_sel +: 8]    <= dl_data;
				2'd2:    code_compare[8*byte_sel +: 8] <= dl_data;
				default: code_replace[8*byte_sel +: 8] <= dl_data;
			endcase
		end
	end

	// Record complete after the last offset
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= code_wr && (ofs == OFS_W'(cart_pkg::CHEAT_BYTES - 1));
		end
	end

endmodule

//--- verilog/rom_store.sv
`timescale 1ns/1ps
// Cartridge ROM memory with a toggle write port of fixed ack delay and a masked read port
module rom_store #(
	parameter int ROM_AW     = 16,
	parameter int WR_LATENCY = 3
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              wr_req,
	input  logic [ROM_AW-1:0] wr_addr,
	input  cart_pkg::byte_t   wr_data,
	output logic              wr_ack,
	input  logic [ROM_AW-1:0] rd_addr,
	input  logic [ROM_AW-1:0] cart_mask,
	output cart_pkg::byte_t   rd_data
);

	cart_pkg::byte_t       mem [2**ROM_AW];
	logic [WR_LATENCY-1:0] req_pipe;  // Delayed copies of the request
	logic                  req_flip;

	// Stage zero holds the last request seen
	assign req_flip = wr_req ^ req_pipe[0];

	// ========================================================================
	// Write port
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			req_pipe <= '0;
			wr_ack   <= 1'b0;
		end else begin
			req_pipe[0] <= wr_req;
			for (int i = 1; i < WR_LATENCY; i++) begin
				req_pipe[i] <= req_pipe[i-1];
			end
			wr_ack <= req_pipe[WR_LATENCY-1]; // Ack WR_LATENCY cycles after the flip
		end
	end

	// Byte goes in as soon as the flip is seen
	always_ff @(posedge clk_sys) begin
		if (req_flip) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ========================================================================
	// Read port
	// ========================================================================

	// Wraps inside the loaded image
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr & cart_mask];
	end

endmodule
